/* knight_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Knight command processor shared definitions.
// Holds the command opcodes, the field widths and the constants for
// the speed ramp, the IR nudge and the heading tolerance.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package knight_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  parameter int cmd_w     = 16;  // Command word from the host.
  parameter int heading_w = 12;  // Signed heading and error.
  parameter int frwrd_w   = 10;  // Forward-speed register.
  parameter int squares_w = 4;   // Square count, cmd[3:0].
  parameter int pulse_w   = 5;   // Two centre-IR edges per square.

  // Opcode lives in the top nibble of the command.
  typedef enum logic [3:0] {
    CAL     = 4'd2,  // Gyro calibration.
    MOV     = 4'd4,  // Plain move.
    FANFARE = 4'd5,  // Move, then fanfare.
    TOUR    = 4'd6   // Hand over to the tour logic.
  } op_t;

  //////////////////////////////////////////////////////////////////////
  // Speed ramp steps
  //////////////////////////////////////////////////////////////////////
  parameter int inc_fast = 32;  // Ramp-up step, short sims.
  parameter int inc_slow = 3;   // Ramp-up step, real robot.
  parameter int dec_fast = 64;  // Ramp-down step, short sims.
  parameter int dec_slow = 6;   // Ramp-down step, real robot.

  // IR nudge magnitudes, added with sign to the heading error.
  parameter int nudge_fast = 511;
  parameter int nudge_slow = 95;

  // Heading counts as aligned when |error| is below this.
  parameter int heading_tol = 44;

endpackage

`default_nettype wire

/* speed_ramp.sv */
//////////////////////////////////////////////////////////////////////
// Forward-speed ramp.
// Clears on request, steps up toward the top speed and steps down
// with saturation at zero, one step per new gyro reading.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module speed_ramp #(
  parameter bit FAST_SIM = 1'b1  // Large steps for simulation.
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clr_frwrd,    // Restart from standstill.
  input  logic                          inc_frwrd,    // Ramp up level.
  input  logic                          dec_frwrd,    // Ramp down level.
  input  logic                          heading_rdy,  // New gyro reading strobe.
  output logic [knight_pkg::frwrd_w-1:0] frwrd,       // Forward speed.
  output logic                          frwrd_zero    // Robot has stopped.
);

  import knight_pkg::*;

  localparam logic [frwrd_w-1:0] inc_amt = frwrd_w'(FAST_SIM ? inc_fast : inc_slow);
  localparam logic [frwrd_w-1:0] dec_amt = frwrd_w'(FAST_SIM ? dec_fast : dec_slow);

  logic max_spd;  // Both top bits set.

  assign max_spd    = &frwrd[frwrd_w-1 -: 2];  // Top speed is 0x300 and up.
  assign frwrd_zero = (frwrd == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (clr_frwrd) begin
      frwrd <= '0;                              // Fresh start of a move.
    end else if (heading_rdy) begin
      if (inc_frwrd && !max_spd) begin
        frwrd <= frwrd + inc_amt;               // Climb until top speed.
      end else if (dec_frwrd) begin
        if (frwrd > dec_amt)
          frwrd <= frwrd - dec_amt;
        else
          frwrd <= '0;                          // Clamp, never wrap.
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  // The sequencer never ramps both ways at once.
  a_inc_dec_excl : assert property (
    @(posedge clk) disable iff (!rst_n) !(inc_frwrd && dec_frwrd)
  ) else $error("speed_ramp: inc_frwrd and dec_frwrd high together");

endmodule

`default_nettype wire

/* square_counter.sv */
//////////////////////////////////////////////////////////////////////
// Square counter.
// Counts rising edges of the centre IR sensor against a target that
// is latched from the command. Two edges make one board square.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module square_counter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cntr_ir,    // Centre IR, high over a line.
  input  logic                         load,       // Move command accepted.
  input  logic [knight_pkg::cmd_w-1:0] cmd,        // Command word.
  output logic                         move_done   // Requested squares covered.
);

  import knight_pkg::*;

  logic                 cntr_ir_q;  // Last sample of cntr_ir.
  logic                 ir_rise;    // Line just entered.
  logic [squares_w-1:0] target;     // Squares to travel.
  logic [pulse_w-1:0]   pulse_cnt;  // Edges since the accept.

  assign ir_rise = cntr_ir & ~cntr_ir_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cntr_ir_q <= 1'b0;
    else
      cntr_ir_q <= cntr_ir;  // Edge detect delay.
  end

  // Target comes straight from cmd at the accept.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      target <= '0;
    else if (load)
      target <= cmd[squares_w-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pulse_cnt <= '0;
    else if (load)
      pulse_cnt <= '0;               // New move, new count.
    else if (ir_rise)
      pulse_cnt <= pulse_cnt + 1'b1;
  end

  // Twice the target, so the shift fills pulse_w exactly.
  assign move_done = (pulse_cnt == {target, 1'b0});

endmodule

`default_nettype wire

/* heading_error.sv */
//////////////////////////////////////////////////////////////////////
// Heading error for the PID.
// Latches the commanded heading, adds the IR nudge and tells the
// sequencer when the robot points close enough to start moving.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module heading_error #(
  parameter bit FAST_SIM = 1'b1  // Large nudge for simulation.
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   load,        // Move command accepted.
  input  logic        [knight_pkg::cmd_w-1:0]     cmd,         // Command word.
  input  logic signed [knight_pkg::heading_w-1:0] heading,     // Gyro heading.
  input  logic                                   lft_ir,      // Drifting left.
  input  logic                                   rght_ir,     // Drifting right.
  output logic signed [knight_pkg::heading_w-1:0] error,       // To the PID.
  output logic                                   heading_ok   // Within tolerance.
);

  import knight_pkg::*;

  localparam logic signed [heading_w-1:0] nudge_amt =
    heading_w'(FAST_SIM ? nudge_fast : nudge_slow);
  localparam logic [heading_w-1:0] tol = heading_w'(heading_tol);

  logic signed [heading_w-1:0] desired;    // Commanded heading.
  logic signed [heading_w-1:0] nudge;      // IR correction.
  logic        [heading_w-1:0] error_abs;  // Magnitude of error.
  logic        [7:0]           hdg_field;  // cmd[11:4].

  assign hdg_field = cmd[11:4];

  //////////////////////////////////////////////////////////////////////
  // Desired heading
  //////////////////////////////////////////////////////////////////////
  // Latched at the accept so the error is valid in the first MOVE cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired <= '0;
    end else if (load) begin
      if (hdg_field == 8'h00)
        desired <= '0;                   // North stays exactly zero.
      else
        desired <= {hdg_field, 4'hF};    // Pad the low nibble with ones.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error and tolerance
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (lft_ir)
      nudge = nudge_amt;                 // Left sensor wins a tie.
    else if (rght_ir)
      nudge = -nudge_amt;
    else
      nudge = '0;
  end

  assign error = heading - desired + nudge;  // Wraps like the heading.

  // Negating the most negative value still reads large as unsigned.
  assign error_abs  = error[heading_w-1] ? -error : error;
  assign heading_ok = (error_abs < tol);

endmodule

`default_nettype wire

/* cmd_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Command sequencer FSM.
// Accepts a command under the cmd_rdy / clr_cmd_rdy handshake and
// walks the robot through calibration, tour start or a move with
// speed ramp up and down, ending in a response to the host.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_rdy,      // Host has a command.
  input  logic [knight_pkg::cmd_w-1:0] cmd,          // Command word.
  input  logic                         cal_done,     // Gyro calibration finished.
  input  logic                         heading_ok,   // Pointing the right way.
  input  logic                         move_done,    // Squares covered.
  input  logic                         frwrd_zero,   // Speed back at zero.
  output logic                         clr_cmd_rdy,  // Command consumed.
  output logic                         load,         // Latch move fields.
  output logic                         strt_cal,     // Kick gyro calibration.
  output logic                         send_resp,    // Reply to the host.
  output logic                         tour_go,      // Start the tour logic.
  output logic                         fanfare_go,   // Start the fanfare tune.
  output logic                         moving,       // Robot under way.
  output logic                         clr_frwrd,    // Zero the speed.
  output logic                         inc_frwrd,    // Ramp speed up.
  output logic                         dec_frwrd     // Ramp speed down.
);

  import knight_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    CALIBRATE,
    MOVE,
    RAMP_UP,
    RAMP_DOWN
  } state_t;

  state_t state;     // Current state.
  state_t nxt_state; // Next state.
  op_t    cmd_op;    // Opcode on the command bus.
  op_t    op_q;      // Opcode of the running command.
  logic   accept;    // Handshake cycle.

  assign cmd_op = op_t'(cmd[cmd_w-1 -: $bits(op_t)]);
  assign accept = (state == IDLE) && cmd_rdy;

  //////////////////////////////////////////////////////////////////////
  // State and opcode registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  // Opcode is held so cmd may change after the accept.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      op_q <= MOV;
    else if (accept)
      op_q <= cmd_op;
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    load        = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;

    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;          // Reply in the first done cycle.
          nxt_state = IDLE;
        end
      end

      MOVE: begin
        if (heading_ok) begin        // Start rolling once aligned.
          moving    = 1'b1;
          clr_frwrd = 1'b1;
          nxt_state = RAMP_UP;
        end
      end

      RAMP_UP: begin
        moving    = 1'b1;
        inc_frwrd = 1'b1;
        if (move_done) begin
          fanfare_go = (op_q == FANFARE);  // One pulse at the last square.
          nxt_state  = RAMP_DOWN;
        end
      end

      RAMP_DOWN: begin
        dec_frwrd = 1'b1;
        if (frwrd_zero) begin
          send_resp = 1'b1;          // Move complete once stopped.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;             // Still coasting down.
        end
      end

      default: begin                 // IDLE waits for the host.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;
          case (cmd_op)
            TOUR: tour_go = 1'b1;    // Stays idle with no response.
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              load      = 1'b1;      // Latch heading and squares.
              nxt_state = MOVE;
            end
            default: ;               // Unknown opcode is dropped.
          endcase
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  // Host drops cmd_rdy on the edge after the accept.
  a_rdy_drops : assert property (
    @(posedge clk) disable iff (!rst_n) clr_cmd_rdy |=> !cmd_rdy
  ) else $error("cmd_sequencer: cmd_rdy still high after clr_cmd_rdy");

  // Host keeps the command word steady while it waits.
  a_cmd_stable : assert property (
    @(posedge clk) disable iff (!rst_n) (cmd_rdy && !clr_cmd_rdy) |=> $stable(cmd)
  ) else $error("cmd_sequencer: cmd changed while cmd_rdy waited");

endmodule

`default_nettype wire

/* knight_cmd_proc.sv */
//////////////////////////////////////////////////////////////////////
// Knight command processor, top level.
// Ties the command FSM to the speed ramp, the square counter and the
// heading error block. FAST_SIM picks the simulation step sizes.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module knight_cmd_proc #(
  parameter bit FAST_SIM = 1'b1  // Passed down to ramp and nudge.
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic        [knight_pkg::cmd_w-1:0]     cmd,          // Command from the host.
  input  logic                                   cmd_rdy,      // Command valid.
  output logic                                   clr_cmd_rdy,  // Command taken.
  output logic                                   send_resp,    // Command finished.
  output logic                                   strt_cal,     // Gyro calibration start.
  input  logic                                   cal_done,     // Gyro calibration done.
  input  logic signed [knight_pkg::heading_w-1:0] heading,      // Gyro heading.
  input  logic                                   heading_rdy,  // New heading strobe.
  input  logic                                   lft_ir,       // Left IR sensor.
  input  logic                                   cntr_ir,      // Centre IR sensor.
  input  logic                                   rght_ir,      // Right IR sensor.
  output logic signed [knight_pkg::heading_w-1:0] error,        // Error to the PID.
  output logic        [knight_pkg::frwrd_w-1:0]   frwrd,        // Forward speed.
  output logic                                   moving,       // Robot under way.
  output logic                                   tour_go,      // Tour start pulse.
  output logic                                   fanfare_go    // Fanfare start pulse.
);

  import knight_pkg::*;

  logic load;        // Move accepted.
  logic clr_frwrd;   // Speed clear.
  logic inc_frwrd;   // Speed up.
  logic dec_frwrd;   // Speed down.
  logic frwrd_zero;  // Speed at zero.
  logic move_done;   // Squares covered.
  logic heading_ok;  // Aligned.

  cmd_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_rdy     (cmd_rdy),
    .cmd         (cmd),
    .cal_done    (cal_done),
    .heading_ok  (heading_ok),
    .move_done   (move_done),
    .frwrd_zero  (frwrd_zero),
    .clr_cmd_rdy (clr_cmd_rdy),
    .load        (load),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd)
  );

  speed_ramp #(
    .FAST_SIM (FAST_SIM)
  ) u_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .frwrd_zero  (frwrd_zero)
  );

  square_counter u_squares (
    .clk       (clk),
    .rst_n     (rst_n),
    .cntr_ir   (cntr_ir),
    .load      (load),
    .cmd       (cmd),
    .move_done (move_done)
  );

  heading_error #(
    .FAST_SIM (FAST_SIM)
  ) u_hdg (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .cmd        (cmd),
    .heading    (heading),
    .lft_ir     (lft_ir),
    .rght_ir    (rght_ir),
    .error      (error),
    .heading_ok (heading_ok)
  );

endmodule

`default_nettype wire

/* tb_knight_cmd_proc.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the knight command processor.
// Applies a table of commands with a small robot model behind the
// DUT and checks the handshake, pulses, heading error and speed.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_knight_cmd_proc;

  import knight_pkg::*;

  localparam int n_rows      = 10;                  // Commands in the table.
  localparam int max_gap     = 10;                  // Longest cntr_ir toggle gap.
  localparam int max_sq      = 15;                  // Largest square field.
  localparam int ramp_cycles = 4 * (768 / inc_fast + 768 / dec_fast) + 60;
  localparam int row_budget  = max_sq * 2 * 2 * max_gap + ramp_cycles;
  localparam int cyc_limit   = (n_rows + 1) * row_budget;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic [cmd_w-1:0]            cmd;
  logic                        cmd_rdy;
  logic                        clr_cmd_rdy;
  logic                        send_resp;
  logic                        strt_cal;
  logic                        cal_done = 1'b0;     // From the robot model.
  logic signed [heading_w-1:0] heading;
  logic                        heading_rdy = 1'b0;  // From the robot model.
  logic                        lft_ir;
  logic                        cntr_ir = 1'b0;      // From the robot model.
  logic                        rght_ir;
  logic signed [heading_w-1:0] error;
  logic [frwrd_w-1:0]          frwrd;
  logic                        moving;
  logic                        tour_go;
  logic                        fanfare_go;

  integer seed = 11201;
  int     cyc_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     row_errs;
  string  cur_name = "reset";

  // Event counters are cleared at the start of every row.
  int   resp_cnt, tour_cnt, fan_cnt, cal_cnt, move_cyc, edge_cnt, fan_cyc, resp_cyc;
  logic cntr_q = 1'b0;                              // Last cntr_ir seen by the monitor.
  logic [frwrd_w-1:0] frwrd_q = '0;                 // Last frwrd seen by the monitor.
  int   fw_now, fw_prev;

  // Model state.
  logic [1:0] hr_cnt;
  int         gap_left;
  int         cal_wait;

  // Command table.
  string                       row_name [n_rows];
  op_t                         row_op   [n_rows];
  logic [7:0]                  row_hdg  [n_rows];
  logic [squares_w-1:0]        row_sq   [n_rows];
  logic signed [heading_w-1:0] row_head [n_rows];
  logic [1:0]                  row_ir   [n_rows];   // {lft_ir, rght_ir}.
  int                          row_err  [n_rows];
  bit                          row_resp [n_rows];
  bit                          row_tour [n_rows];
  bit                          row_fan  [n_rows];
  int                          fill_idx = 0;

  always #4 clk = ~clk;                             // 8 ns period.

  knight_cmd_proc #(.FAST_SIM(1'b1)) UUT (
    .clk (clk), .rst_n (rst_n), .cmd (cmd), .cmd_rdy (cmd_rdy),
    .clr_cmd_rdy (clr_cmd_rdy), .send_resp (send_resp), .strt_cal (strt_cal),
    .cal_done (cal_done), .heading (heading), .heading_rdy (heading_rdy),
    .lft_ir (lft_ir), .cntr_ir (cntr_ir), .rght_ir (rght_ir), .error (error),
    .frwrd (frwrd), .moving (moving), .tour_go (tour_go), .fanfare_go (fanfare_go)
  );

  function automatic int rand_range(input int lo, input int hi);
    rand_range = lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Robot model
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst_n) begin
      hr_cnt      <= 2'd0;
      heading_rdy <= 1'b0;
    end else begin
      hr_cnt      <= hr_cnt + 2'd1;
      heading_rdy <= (hr_cnt == 2'd3);              // Gyro reading every 4 cycles.
    end
  end

  // Centre IR crosses lines only while the robot rolls.
  always @(posedge clk) begin
    if (!rst_n || !moving) begin
      cntr_ir  <= 1'b0;
      gap_left <= 0;
    end else if (gap_left == 0) begin
      gap_left <= rand_range(3, max_gap);           // Arm the first gap.
    end else if (gap_left == 1) begin
      cntr_ir  <= ~cntr_ir;
      gap_left <= rand_range(3, max_gap);
    end else begin
      gap_left <= gap_left - 1;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      cal_done <= 1'b0;
      cal_wait <= 0;
    end else if (strt_cal) begin
      cal_done <= 1'b0;
      cal_wait <= rand_range(2, 9);                 // Gyro settles a while.
    end else if (cal_wait == 1) begin
      cal_done <= 1'b1;
      cal_wait <= 0;
    end else begin
      cal_done <= 1'b0;
      if (cal_wait != 0) cal_wait <= cal_wait - 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and monitor
  //////////////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string what, input int exp, input int act);
    $display("** Error %s: %s expected %0d, actual %0d", cur_name, what, exp, act);
    row_errs++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s: %s", cur_name, msg);
    row_errs++;
  endtask

  task automatic close_test();
    if (row_errs == 0) begin
      pass_cnt++;
      $display("PASS  %s", cur_name);
    end else begin
      fail_cnt++;
      $display("FAIL  %s (%0d errors)", cur_name, row_errs);
    end
  endtask

  always @(posedge clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt >= cyc_limit) begin
      $display("timeout: no terminating event");
      $display("TEST FAILED");
      $finish;
    end
  end

  // Counts pulses and watches every frwrd step between the edges.
  always @(negedge clk) begin
    if (rst_n) begin
      if (send_resp) begin
        resp_cnt++;
        resp_cyc = cyc_cnt;
      end
      if (fanfare_go) begin
        fan_cnt++;
        fan_cyc = cyc_cnt;
      end
      if (tour_go) tour_cnt++;
      if (strt_cal) cal_cnt++;
      if (moving) move_cyc++;
      if (cntr_ir && !cntr_q) edge_cnt++;          // Line entered.
      fw_now  = frwrd;
      fw_prev = frwrd_q;
      if (fw_now > 'h300)
        report_mismatch("frwrd ceiling", 'h300, fw_now);
      else if (fw_now != fw_prev && fw_now != 0 && fw_now != fw_prev + inc_fast &&
               !(fw_prev > dec_fast && fw_now == fw_prev - dec_fast))
        report_fault($sformatf("frwrd jumped from %0d to %0d, not a ramp step",
                               fw_prev, fw_now));
    end
    cntr_q  = cntr_ir;
    frwrd_q = frwrd;
  end

  //////////////////////////////////////////////////////////////////////
  // Table and row runner
  //////////////////////////////////////////////////////////////////////
  task automatic add_row(input string nm, input op_t op, input logic [7:0] hdg,
                         input int sq, input int head, input logic [1:0] ir,
                         input int err, input bit resp, input bit tour, input bit fan);
    row_name[fill_idx] = nm;
    row_op[fill_idx]   = op;
    row_hdg[fill_idx]  = hdg;
    row_sq[fill_idx]   = sq;
    row_head[fill_idx] = head;
    row_ir[fill_idx]   = ir;
    row_err[fill_idx]  = err;
    row_resp[fill_idx] = resp;
    row_tour[fill_idx] = tour;
    row_fan[fill_idx]  = fan;
    fill_idx++;
  endtask

  task automatic run_row(input int idx);
    logic signed [heading_w-1:0] fixed_hdg;
    int                          want_edges;
    bit                          is_move;
    bit                          held_bad;
    cur_name   = row_name[idx];
    row_errs   = 0;
    is_move    = (row_op[idx] == MOV) || (row_op[idx] == FANFARE);
    want_edges = 2 * row_sq[idx];                   // Two edges per square.
    held_bad   = 1'b0;
    @(posedge clk);
    resp_cnt = 0;
    tour_cnt = 0;
    fan_cnt  = 0;
    cal_cnt  = 0;
    move_cyc = 0;
    edge_cnt = 0;
    fan_cyc  = -1;
    resp_cyc = -1;
    cmd     <= {row_op[idx], row_hdg[idx], row_sq[idx]};
    cmd_rdy <= 1'b1;
    heading <= row_head[idx];
    lft_ir  <= row_ir[idx][1];
    rght_ir <= row_ir[idx][0];
    @(negedge clk);
    while (clr_cmd_rdy !== 1'b1) @(negedge clk);   // Accept cycle.
    if (tour_go !== row_tour[idx])
      report_mismatch("tour_go at accept", row_tour[idx], tour_go);
    if (strt_cal !== (row_op[idx] == CAL))
      report_mismatch("strt_cal at accept", row_op[idx] == CAL, strt_cal);
    @(posedge clk);
    cmd_rdy <= 1'b0;
    cmd     <= ~cmd;                                // Bus changes after the accept.
    if (is_move) begin
      @(negedge clk);                               // First MOVE cycle.
      if (error !== row_err[idx])
        report_mismatch("error in first MOVE cycle", row_err[idx], error);
      if ((row_err[idx] < 0 ? -row_err[idx] : row_err[idx]) >= heading_tol) begin
        repeat (20) begin
          @(negedge clk);
          if ((moving !== 1'b0 || send_resp !== 1'b0) && !held_bad) begin
            report_fault("robot started with the heading out of tolerance");
            held_bad = 1'b1;
          end
        end
        fixed_hdg = row_head[idx] - row_err[idx];  // Point the robot right.
        @(posedge clk);
        heading <= fixed_hdg;
        @(negedge clk);
        if (error !== 0) report_mismatch("error after heading fix", 0, error);
      end
    end
    if (row_resp[idx]) begin
      @(negedge clk);
      while (send_resp !== 1'b1) @(negedge clk);
      if (frwrd !== '0) report_mismatch("frwrd at send_resp", 0, frwrd);
      if (is_move && edge_cnt < want_edges)
        report_mismatch("cntr_ir rising edges before send_resp", want_edges, edge_cnt);
      if (row_op[idx] == CAL && cal_done !== 1'b1)
        report_fault("send_resp came before cal_done");
    end else begin
      repeat (20) @(negedge clk);                   // No response may follow.
    end
    @(posedge clk);
    lft_ir  <= 1'b0;
    rght_ir <= 1'b0;
    repeat (2) @(negedge clk);
    if (resp_cnt != row_resp[idx]) report_mismatch("send_resp pulses", row_resp[idx], resp_cnt);
    if (tour_cnt != row_tour[idx]) report_mismatch("tour_go pulses", row_tour[idx], tour_cnt);
    if (fan_cnt != row_fan[idx]) report_mismatch("fanfare_go pulses", row_fan[idx], fan_cnt);
    if (cal_cnt != (row_op[idx] == CAL))
      report_mismatch("strt_cal pulses", row_op[idx] == CAL, cal_cnt);
    if (!is_move && move_cyc != 0) report_fault("moving went high without a move command");
    if (row_fan[idx] && fan_cyc >= resp_cyc)
      report_fault("fanfare_go did not come before send_resp");
    close_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_rdy = 1'b0;
    heading = '0;
    lft_ir  = 1'b0;
    rght_ir = 1'b0;
    //       name             op       hdg    sq  head   ir     err  resp tour fan
    add_row("tour",          TOUR,    8'h00, 0,  0,     2'b00, 0,    0, 1, 0);
    add_row("cal",           CAL,     8'h00, 0,  0,     2'b00, 0,    1, 0, 0);
    add_row("mov_north",     MOV,     8'h00, 2,  10,    2'b00, 10,   1, 0, 0);
    add_row("mov_east",      MOV,     8'h3F, 9,  1040,  2'b00, 17,   1, 0, 0);
    add_row("fanfare_south", FANFARE, 8'h7F, 1,  2030,  2'b00, -17,  1, 0, 1);
    add_row("mov_west",      MOV,     8'hBF, 2,  -1000, 2'b00, 25,   1, 0, 0);
    add_row("heading_off",   MOV,     8'h00, 1,  100,   2'b00, 100,  1, 0, 0);
    add_row("nudge_left",    MOV,     8'h00, 1,  0,     2'b10, 511,  1, 0, 0);
    add_row("nudge_right",   FANFARE, 8'h3F, 2,  1023,  2'b01, -511, 1, 0, 1);
    add_row("both_ir",       MOV,     8'h7F, 1,  2047,  2'b11, 511,  1, 0, 0);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    row_errs = 0;
    @(negedge clk);
    if ({clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go} !== 6'b0)
      report_fault("a control output is high after reset");
    if (frwrd !== '0) report_mismatch("frwrd after reset", 0, frwrd);
    close_test();
    for (int i = 0; i < n_rows; i++) run_row(i);
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
knight_pkg.sv
speed_ramp.sv
square_counter.sv
heading_error.sv
cmd_sequencer.sv
knight_cmd_proc.sv
tb_knight_cmd_proc.sv

/* Bender.yml */
package:
  name: knight_cmd_proc

sources:
  - knight_pkg.sv
  - speed_ramp.sv
  - square_counter.sv
  - heading_error.sv
  - cmd_sequencer.sv
  - knight_cmd_proc.sv
  - target: simulation
    files:
      - tb_knight_cmd_proc.sv
